// File: verilog/core_pkg.sv
package core_pkg;

	//////////////////////////////
	// sizes
	//////////////////////////////

	localparam int data_width = 16;
	localparam int reg_count = 8;
	localparam int reg_w = 3;
	localparam int rob_depth = 8;
	localparam int tag_w = 3;
	localparam int alu_count = 2;

	//////////////////////////////
	// instruction word
	//////////////////////////////

	typedef enum logic [1:0] {
		OP_ADD = 2'd0,
		OP_SUB = 2'd1,
		OP_XOR = 2'd2,
		OP_ADDI = 2'd3
	} op_t;

	// register form, low bits unused
	typedef struct packed {
		op_t op;
		logic [reg_w-1:0] rd;
		logic [reg_w-1:0] rs1;
		logic [reg_w-1:0] rs2;
		logic [4:0] pad;
	} inst_r_t;

	// immediate form, imm is two's complement
	typedef struct packed {
		op_t op;
		logic [reg_w-1:0] rd;
		logic [reg_w-1:0] rs1;
		logic signed [7:0] imm;
	} inst_i_t;

	typedef union packed {
		inst_r_t r;
		inst_i_t i;
	} inst_word_u;

endpackage

// File: verilog/core_ifs.sv
`timescale 1ns/1ps

// issue unit to one station
interface dispatch_if;
	import core_pkg::*;

	logic valid;
	op_t op;
	logic [tag_w-1:0] tag;
	logic a_ready;
	logic [tag_w-1:0] a_tag;
	logic [data_width-1:0] a_data;
	logic b_ready;
	logic [tag_w-1:0] b_tag;
	logic [data_width-1:0] b_data;
	logic busy;

	modport driver (
		output valid, op, tag, a_ready, a_tag, a_data, b_ready, b_tag, b_data,
		input busy
	);
	modport station (
		input valid, op, tag, a_ready, a_tag, a_data, b_ready, b_tag, b_data,
		output busy
	);
endinterface

// one station asking for the cdb
interface result_if;
	import core_pkg::*;

	logic req;
	logic grant;
	logic [tag_w-1:0] tag;
	logic [data_width-1:0] data;

	modport requester (output req, tag, data, input grant);
	modport arbiter (input req, tag, data, output grant);
endinterface

// File: verilog/issue_unit.sv
`timescale 1ns/1ps

module issue_unit (
	input logic clk,
	input logic rst_n,
	input logic inst_valid,
	input core_pkg::inst_word_u inst,
	output logic inst_ready,
	input logic rob_full,
	input logic [core_pkg::tag_w-1:0] rob_tail_tag,
	output logic rob_alloc,
	output logic [core_pkg::reg_w-1:0] rf_rs1,
	output logic [core_pkg::reg_w-1:0] rf_rs2,
	input logic [1:0] rf_busy,
	input logic [core_pkg::tag_w-1:0] rf_tag [2],
	input logic [core_pkg::data_width-1:0] rf_data [2],
	output logic [core_pkg::tag_w-1:0] rob_rd_tag [2],
	input logic [1:0] rob_rd_done,
	input logic [core_pkg::data_width-1:0] rob_rd_data [2],
	input logic cdb_valid,
	input logic [core_pkg::tag_w-1:0] cdb_tag,
	input logic [core_pkg::data_width-1:0] cdb_data,
	output logic [core_pkg::reg_w-1:0] issue_rd,
	output logic [core_pkg::tag_w-1:0] issue_tag,
	dispatch_if.driver stations [core_pkg::alu_count]
);
	import core_pkg::*;

	logic accept;
	logic is_imm;
	logic [alu_count-1:0] free;
	logic [alu_count-1:0] pick;
	logic [1:0] src_ready;
	logic [data_width-1:0] src_data [2];

	// dispatch register, disp_sel is one-hot and doubles as valid
	logic [alu_count-1:0] disp_sel;
	op_t disp_op;
	logic [tag_w-1:0] disp_tag;
	logic [1:0] disp_ready;
	logic [tag_w-1:0] disp_src_tag [2];
	logic [data_width-1:0] disp_data [2];

	//////////////////////////////
	// station choice
	//////////////////////////////

	// a station with a dispatch in flight is not free yet
	for (genvar g = 0; g < alu_count; g++) begin : g_free
		assign free[g] = !stations[g].busy && !disp_sel[g];
	end

	// lowest free station
	assign pick = free & (-free);

	assign inst_ready = !rob_full && (|free);
	assign accept = inst_valid && inst_ready;

	//////////////////////////////
	// decode and operand lookup
	//////////////////////////////

	assign is_imm = inst.r.op == OP_ADDI;
	assign rf_rs1 = inst.r.rs1;
	assign rf_rs2 = inst.r.rs2;
	assign rob_rd_tag[0] = rf_tag[0];
	assign rob_rd_tag[1] = rf_tag[1];

	always_comb begin
		for (int k = 0; k < 2; k++) begin
			if (!rf_busy[k]) begin
				src_ready[k] = 1'b1;
				src_data[k] = rf_data[k];
			end else if (rob_rd_done[k]) begin
				src_ready[k] = 1'b1;
				src_data[k] = rob_rd_data[k];
			end else if (cdb_valid && cdb_tag == rf_tag[k]) begin
				src_ready[k] = 1'b1;
				src_data[k] = cdb_data;
			end else begin
				src_ready[k] = 1'b0;
				src_data[k] = rf_data[k];
			end
		end
		// immediate replaces rs2
		if (is_imm) begin
			src_ready[1] = 1'b1;
			src_data[1] = {{(data_width - 8){inst.i.imm[7]}}, inst.i.imm};
		end
	end

	assign rob_alloc = accept;
	assign issue_rd = inst.r.rd;
	assign issue_tag = rob_tail_tag;

	//////////////////////////////
	// dispatch
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			disp_sel <= '0;
		else
			disp_sel <= accept ? pick : '0;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			disp_op <= inst.r.op;
			disp_tag <= rob_tail_tag;
			disp_ready <= src_ready;
			for (int k = 0; k < 2; k++) begin
				disp_src_tag[k] <= rf_tag[k];
				disp_data[k] <= src_data[k];
			end
		end
	end

	for (genvar g = 0; g < alu_count; g++) begin : g_disp
		assign stations[g].valid = disp_sel[g];
		assign stations[g].op = disp_op;
		assign stations[g].tag = disp_tag;
		assign stations[g].a_ready = disp_ready[0];
		assign stations[g].a_tag = disp_src_tag[0];
		assign stations[g].a_data = disp_data[0];
		assign stations[g].b_ready = disp_ready[1];
		assign stations[g].b_tag = disp_src_tag[1];
		assign stations[g].b_data = disp_data[1];
	end

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input logic clk,
	input logic rst_n,
	input logic [core_pkg::reg_w-1:0] rs1,
	input logic [core_pkg::reg_w-1:0] rs2,
	output logic [1:0] busy,
	output logic [core_pkg::tag_w-1:0] tag [2],
	output logic [core_pkg::data_width-1:0] data [2],
	input logic issue_valid,
	input logic [core_pkg::reg_w-1:0] issue_rd,
	input logic [core_pkg::tag_w-1:0] issue_tag,
	input logic commit_valid,
	input logic [core_pkg::reg_w-1:0] commit_rd,
	input logic [core_pkg::tag_w-1:0] commit_tag,
	input logic [core_pkg::data_width-1:0] commit_data
);
	import core_pkg::*;

	logic [data_width-1:0] regs [reg_count];
	logic [reg_count-1:0] reg_busy;
	logic [tag_w-1:0] reg_tag [reg_count];

	// read ports
	assign busy[0] = reg_busy[rs1];
	assign busy[1] = reg_busy[rs2];
	assign tag[0] = reg_tag[rs1];
	assign tag[1] = reg_tag[rs2];
	assign data[0] = regs[rs1];
	assign data[1] = regs[rs2];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			reg_busy <= '0;
			for (int i = 0; i < reg_count; i++) begin
				regs[i] <= '0;
				reg_tag[i] <= '0;
			end
		end else begin
			if (commit_valid)
				regs[commit_rd] <= commit_data;
			for (int i = 0; i < reg_count; i++) begin
				// a newer issue keeps the register busy
				if (issue_valid && issue_rd == reg_w'(i)) begin
					reg_busy[i] <= 1'b1;
					reg_tag[i] <= issue_tag;
				end else if (commit_valid && commit_rd == reg_w'(i) &&
						reg_tag[i] == commit_tag) begin
					reg_busy[i] <= 1'b0;
				end
			end
		end
	end

endmodule

// File: verilog/rob.sv
`timescale 1ns/1ps

module rob (
	input logic clk,
	input logic rst_n,
	input logic alloc,
	input logic [core_pkg::reg_w-1:0] alloc_rd,
	output logic full,
	output logic [core_pkg::tag_w-1:0] tail_tag,
	input logic [core_pkg::tag_w-1:0] rd_tag [2],
	output logic [1:0] rd_done,
	output logic [core_pkg::data_width-1:0] rd_data [2],
	input logic cdb_valid,
	input logic [core_pkg::tag_w-1:0] cdb_tag,
	input logic [core_pkg::data_width-1:0] cdb_data,
	output logic commit_valid,
	output logic [core_pkg::reg_w-1:0] commit_rd,
	output logic [core_pkg::tag_w-1:0] commit_tag,
	output logic [core_pkg::data_width-1:0] commit_data
);
	import core_pkg::*;

	logic [tag_w-1:0] head;
	logic [tag_w-1:0] tail;
	logic [tag_w:0] count;
	logic [rob_depth-1:0] done;
	logic [reg_w-1:0] dest [rob_depth];
	logic [data_width-1:0] value [rob_depth];

	assign full = count == (tag_w + 1)'(rob_depth);
	assign tail_tag = tail;

	// operand forwarding
	for (genvar k = 0; k < 2; k++) begin : g_read
		assign rd_done[k] = done[rd_tag[k]];
		assign rd_data[k] = value[rd_tag[k]];
	end

	// head retires once its result is in
	assign commit_valid = (count != '0) && done[head];
	assign commit_rd = dest[head];
	assign commit_tag = head;
	assign commit_data = value[head];

	//////////////////////////////
	// pointers and done flags
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			done <= '0;
		end else begin
			if (alloc) begin
				done[tail] <= 1'b0;
				tail <= tail + tag_w'(1);
			end
			if (cdb_valid)
				done[cdb_tag] <= 1'b1;
			if (commit_valid)
				head <= head + tag_w'(1);
			count <= count + {{tag_w{1'b0}}, alloc} - {{tag_w{1'b0}}, commit_valid};
		end
	end

	always_ff @(posedge clk) begin
		if (alloc)
			dest[tail] <= alloc_rd;
		if (cdb_valid)
			value[cdb_tag] <= cdb_data;
	end

endmodule

// File: verilog/alu_station.sv
`timescale 1ns/1ps

module alu_station (
	input logic clk,
	input logic rst_n,
	dispatch_if.station disp,
	input logic cdb_valid,
	input logic [core_pkg::tag_w-1:0] cdb_tag,
	input logic [core_pkg::data_width-1:0] cdb_data,
	result_if.requester res
);
	import core_pkg::*;

	logic busy;
	op_t cur_op;
	logic [tag_w-1:0] cur_tag;
	logic [1:0] in_ready;
	logic [tag_w-1:0] in_tag [2];
	logic [data_width-1:0] in_data [2];
	logic [1:0] in_hit;
	logic [1:0] snoop;
	logic [1:0] opnd_ready;
	logic [tag_w-1:0] opnd_tag [2];
	logic [data_width-1:0] opnd_data [2];
	logic [data_width-1:0] result;

	assign in_ready = {disp.b_ready, disp.a_ready};
	assign in_tag[0] = disp.a_tag;
	assign in_tag[1] = disp.b_tag;
	assign in_data[0] = disp.a_data;
	assign in_data[1] = disp.b_data;

	// cdb match on the incoming dispatch and on held operands
	always_comb begin
		for (int k = 0; k < 2; k++) begin
			in_hit[k] = cdb_valid && cdb_tag == in_tag[k];
			snoop[k] = busy && !opnd_ready[k] && cdb_valid && cdb_tag == opnd_tag[k];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			opnd_ready <= '0;
		end else begin
			if (disp.valid)
				busy <= 1'b1;
			else if (res.req && res.grant)
				busy <= 1'b0;
			for (int k = 0; k < 2; k++) begin
				if (disp.valid)
					opnd_ready[k] <= in_ready[k] || in_hit[k];
				else if (snoop[k])
					opnd_ready[k] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (disp.valid) begin
			cur_op <= disp.op;
			cur_tag <= disp.tag;
		end
		for (int k = 0; k < 2; k++) begin
			if (disp.valid) begin
				opnd_tag[k] <= in_tag[k];
				opnd_data[k] <= in_ready[k] ? in_data[k] : cdb_data;
			end else if (snoop[k]) begin
				opnd_data[k] <= cdb_data;
			end
		end
	end

	// alu, addi uses the add path
	always_comb begin
		case (cur_op)
			OP_SUB: result = opnd_data[0] - opnd_data[1];
			OP_XOR: result = opnd_data[0] ^ opnd_data[1];
			default: result = opnd_data[0] + opnd_data[1];
		endcase
	end

	assign disp.busy = busy;
	assign res.req = busy && (&opnd_ready);
	assign res.tag = cur_tag;
	assign res.data = result;

endmodule

// File: verilog/cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter (
	input logic clk,
	input logic rst_n,
	result_if.arbiter reqs [core_pkg::alu_count],
	output logic cdb_valid,
	output logic [core_pkg::tag_w-1:0] cdb_tag,
	output logic [core_pkg::data_width-1:0] cdb_data
);
	import core_pkg::*;

	logic [alu_count-1:0] req;
	logic [alu_count-1:0] grant;
	logic [tag_w-1:0] req_tag [alu_count];
	logic [data_width-1:0] req_data [alu_count];
	logic [tag_w-1:0] last_tag;
	logic [data_width-1:0] last_data;

	for (genvar g = 0; g < alu_count; g++) begin : g_port
		assign req[g] = reqs[g].req;
		assign req_tag[g] = reqs[g].tag;
		assign req_data[g] = reqs[g].data;
		assign reqs[g].grant = grant[g];
	end

	// fixed priority, station 0 first
	assign grant = req & (-req);

	always_comb begin
		cdb_valid = |req;
		cdb_tag = last_tag;
		cdb_data = last_data;
		for (int i = 0; i < alu_count; i++) begin
			if (grant[i]) begin
				cdb_tag = req_tag[i];
				cdb_data = req_data[i];
			end
		end
	end

	// idle bus keeps showing the last transfer
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			last_tag <= '0;
			last_data <= '0;
		end else if (cdb_valid) begin
			last_tag <= cdb_tag;
			last_data <= cdb_data;
		end
	end

endmodule

// File: verilog/ooo_core.sv
`timescale 1ns/1ps

module ooo_core (
	input logic clk,
	input logic rst_n,
	input logic inst_valid,
	input logic [15:0] inst,
	output logic inst_ready,
	output logic commit_valid,
	output logic [core_pkg::reg_w-1:0] commit_rd,
	output logic [core_pkg::data_width-1:0] commit_data
);
	import core_pkg::*;

	logic rob_full;
	logic [tag_w-1:0] rob_tail_tag;
	logic rob_alloc;
	logic [reg_w-1:0] rf_rs1;
	logic [reg_w-1:0] rf_rs2;
	logic [1:0] rf_busy;
	logic [tag_w-1:0] rf_tag [2];
	logic [data_width-1:0] rf_data [2];
	logic [tag_w-1:0] rob_rd_tag [2];
	logic [1:0] rob_rd_done;
	logic [data_width-1:0] rob_rd_data [2];
	logic [reg_w-1:0] issue_rd;
	logic [tag_w-1:0] issue_tag;
	logic [tag_w-1:0] commit_tag;

	// cdb
	logic cdb_valid;
	logic [tag_w-1:0] cdb_tag;
	logic [data_width-1:0] cdb_data;

	dispatch_if disp [alu_count] ();
	result_if res [alu_count] ();

	issue_unit u_issue (
		.clk,
		.rst_n,
		.inst_valid,
		.inst(inst),
		.inst_ready,
		.rob_full,
		.rob_tail_tag,
		.rob_alloc,
		.rf_rs1,
		.rf_rs2,
		.rf_busy,
		.rf_tag,
		.rf_data,
		.rob_rd_tag,
		.rob_rd_done,
		.rob_rd_data,
		.cdb_valid,
		.cdb_tag,
		.cdb_data,
		.issue_rd,
		.issue_tag,
		.stations(disp)
	);

	reg_file u_reg_file (
		.clk,
		.rst_n,
		.rs1(rf_rs1),
		.rs2(rf_rs2),
		.busy(rf_busy),
		.tag(rf_tag),
		.data(rf_data),
		.issue_valid(rob_alloc),
		.issue_rd,
		.issue_tag,
		.commit_valid,
		.commit_rd,
		.commit_tag,
		.commit_data
	);

	rob u_rob (
		.clk,
		.rst_n,
		.alloc(rob_alloc),
		.alloc_rd(issue_rd),
		.full(rob_full),
		.tail_tag(rob_tail_tag),
		.rd_tag(rob_rd_tag),
		.rd_done(rob_rd_done),
		.rd_data(rob_rd_data),
		.cdb_valid,
		.cdb_tag,
		.cdb_data,
		.commit_valid,
		.commit_rd,
		.commit_tag,
		.commit_data
	);

	for (genvar g = 0; g < alu_count; g++) begin : g_station
		alu_station u_station (
			.clk,
			.rst_n,
			.disp(disp[g]),
			.cdb_valid,
			.cdb_tag,
			.cdb_data,
			.res(res[g])
		);
	end

	cdb_arbiter u_arbiter (
		.clk,
		.rst_n,
		.reqs(res),
		.cdb_valid,
		.cdb_tag,
		.cdb_data
	);

endmodule

// File: tests/core_model.svh
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

//////////////////////////////
// random source
//////////////////////////////

logic [31:0] lfsr_state;

// fibonacci lfsr, taps 32 22 2 1
function automatic logic next_bit();
	logic fb;
	fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
	lfsr_state = {lfsr_state[30:0], fb};
	return fb;
endfunction

// up to 8 bits, one step per bit
function automatic logic [7:0] rand_bits(input int n);
	logic [7:0] v;
	v = '0;
	for (int i = 0; i < n; i++)
		v = {v[6:0], next_bit()};
	return v;
endfunction

// random instruction, rs1 optionally forced to an earlier rd
function automatic logic [15:0] make_inst(input bit dep, input logic [2:0] dep_rs1);
	logic [7:0] fld;
	logic [1:0] op;
	logic [2:0] rd;
	logic [2:0] rs1;
	logic [15:0] word;
	fld = rand_bits(2);
	op = fld[1:0];
	fld = rand_bits(3);
	rd = fld[2:0];
	if (dep) begin
		rs1 = dep_rs1;
	end else begin
		fld = rand_bits(3);
		rs1 = fld[2:0];
	end
	if (op == OP_ADDI) begin
		fld = rand_bits(8);
		word = {op, rd, rs1, fld};
	end else begin
		fld = rand_bits(3);
		word = {op, rd, rs1, fld[2:0], 5'b0};
	end
	return word;
endfunction

//////////////////////////////
// in-order reference
//////////////////////////////

logic [data_width-1:0] model_regs [reg_count];
logic [reg_w-1:0] exp_rd_q [$];
logic [data_width-1:0] exp_data_q [$];
int accepted = 0;
int neg_imm_count = 0;

task automatic model_init();
	lfsr_state = 32'h3a58;
	for (int i = 0; i < reg_count; i++)
		model_regs[i] = '0;
endtask

// runs one accepted instruction and queues its commit
task automatic model_issue(input logic [15:0] word);
	logic [1:0] op;
	logic [data_width-1:0] a;
	logic [data_width-1:0] b;
	logic [data_width-1:0] res;
	op = word[15:14];
	a = model_regs[word[10:8]];
	if (op == OP_ADDI) begin
		b = {{(data_width - 8){word[7]}}, word[7:0]};
		if (word[7])
			neg_imm_count++;
	end else begin
		b = model_regs[word[7:5]];
	end
	case (op)
		OP_SUB: res = a - b;
		OP_XOR: res = a ^ b;
		default: res = a + b;
	endcase
	model_regs[word[13:11]] = res;
	exp_rd_q.push_back(word[13:11]);
	exp_data_q.push_back(res);
	accepted++;
endtask

`endif

// File: tests/tb_core.sv
`timescale 1ns/1ps

module tb_core;
	import core_pkg::*;

	localparam int n_inst = 400;
	localparam int cycle_limit = n_inst * 10 + 200;

	logic clk;
	logic rst_n;
	logic inst_valid;
	logic [15:0] inst;
	logic inst_ready;
	logic commit_valid;
	logic [reg_w-1:0] commit_rd;
	logic [data_width-1:0] commit_data;

	int value_errors = 0;
	int other_errors = 0;
	int committed = 0;
	int cycles = 0;
	bit stall_seen = 1'b0;
	logic [reg_w-1:0] exp_rd;
	logic [data_width-1:0] exp_data;
	logic [15:0] word;
	logic [2:0] prev_rd;
	logic [7:0] gap;

	`include "core_model.svh"

	ooo_core uut (
		.clk,
		.rst_n,
		.inst_valid,
		.inst,
		.inst_ready,
		.commit_valid,
		.commit_rd,
		.commit_data
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// hold one instruction until the handshake takes it
	task automatic send_inst(input logic [15:0] w, input bit back_to_back);
		inst_valid <= 1'b1;
		inst <= w;
		@(posedge clk);
		while (!inst_ready) begin
			if (back_to_back)
				stall_seen = 1'b1;
			@(posedge clk);
		end
		model_issue(w);
	endtask

	task automatic print_counts();
		$display("value errors: %0d, other errors: %0d", value_errors, other_errors);
	endtask

	//////////////////////////////
	// stimulus
	//////////////////////////////

	initial begin
		rst_n = 1'b0;
		inst_valid = 1'b0;
		inst = '0;
		prev_rd = '0;
		model_init();
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		@(negedge clk);
		if (commit_valid !== 1'b0) begin
			value_errors++;
			$display("ERR commit_valid: got %h, expected %h", commit_valid, 1'b0);
		end
		if (inst_ready !== 1'b1) begin
			value_errors++;
			$display("ERR inst_ready: got %h, expected %h", inst_ready, 1'b1);
		end
		@(posedge clk);
		// dependent chain, valid never drops
		for (int n = 0; n < n_inst / 2; n++) begin
			word = make_inst(1'b1, prev_rd);
			prev_rd = word[13:11];
			send_inst(word, 1'b1);
		end
		// independent, random idle gaps
		for (int n = n_inst / 2; n < n_inst; n++) begin
			gap = rand_bits(2);
			if (gap != 8'd0) begin
				inst_valid <= 1'b0;
				repeat (int'(gap)) @(posedge clk);
			end
			word = make_inst(1'b0, 3'd0);
			send_inst(word, 1'b0);
		end
		inst_valid <= 1'b0;
		while (committed < accepted)
			@(posedge clk);
		repeat (8) @(posedge clk);
		if (committed != n_inst || accepted != n_inst) begin
			other_errors++;
			$display("%0d sent, %0d accepted, %0d committed", n_inst, accepted, committed);
		end
		if (exp_rd_q.size() != 0) begin
			other_errors++;
			$display("%0d expected commits never arrived", exp_rd_q.size());
		end
		if (!stall_seen) begin
			other_errors++;
			$display("inst_ready never fell during back-to-back issue");
		end
		if (neg_imm_count == 0) begin
			other_errors++;
			$display("no ADDI with a negative immediate was sent");
		end
		print_counts();
		if (value_errors == 0 && other_errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	//////////////////////////////
	// commit monitor
	//////////////////////////////

	// outputs are settled at the falling edge
	always @(negedge clk) begin
		if (rst_n === 1'b1) begin
			if (accepted - committed > rob_depth) begin
				other_errors++;
				$display("%0d instructions in flight, ROB holds %0d",
					accepted - committed, rob_depth);
			end
			if (commit_valid) begin
				if (exp_rd_q.size() == 0) begin
					other_errors++;
					$display("commit with no instruction outstanding");
				end else begin
					exp_rd = exp_rd_q.pop_front();
					exp_data = exp_data_q.pop_front();
					if (commit_rd !== exp_rd) begin
						value_errors++;
						$display("ERR commit_rd: got %h, expected %h", commit_rd, exp_rd);
					end
					if (commit_data !== exp_data) begin
						value_errors++;
						$display("ERR commit_data: got %h, expected %h",
							commit_data, exp_data);
					end
				end
				committed++;
			end
		end
	end

	// watchdog
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout after %0d cycles, %0d of %0d accepted instructions not committed",
				cycles, accepted - committed, accepted);
			print_counts();
			$display("Test FAILED");
			$finish;
		end
	end

endmodule

// File: sources.f
+incdir+tests
verilog/core_pkg.sv
verilog/core_ifs.sv
verilog/issue_unit.sv
verilog/reg_file.sv
verilog/rob.sv
verilog/alu_station.sv
verilog/cdb_arbiter.sv
verilog/ooo_core.sv
tests/tb_core.sv

// File: Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing
LINT_FLAGS = --lint-only --timing
TOP        = tb_core
RTL_TOP    = ooo_core
FILELIST   = sources.f
BUILD      = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^Test OK$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
